// ==== all.f ====
+incdir+common
common/tinker_pkg.sv
verilog/stage_reg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/reg_file.sv
execute/exec_stage.sv
memory/tinker_memory.sv
verilog/commit_stage.sv
verilog/tinker_core.sv
verif/tb_checks.sv
verif/tb_tinker.sv

// ==== common/tinker_macros.svh ====
// Word, instruction, address, register, literal, memory size and reset PC macros
`ifndef TINKER_MACROS_SVH
`define TINKER_MACROS_SVH

`define TK_WORD_W    64             // Data word
`define TK_INSTR_W   32             // Instruction word
`define TK_ADDR_W    32             // Byte address
`define TK_REG_CNT   32             // Architectural registers
`define TK_LIT_W     12             // Instruction literal field

// Unified byte memory, code and data
`define TK_MEM_BYTES 65536

`define TK_RESET_PC  32'h0000_2000  // First fetch address

`endif

// ==== common/tinker_pkg.sv ====
// Tinker word, address, opcode, kind and stage payload types
`include "tinker_macros.svh"

package tinker_pkg;

    typedef logic [`TK_WORD_W-1:0]          word_t;
    typedef logic [`TK_ADDR_W-1:0]          addr_t;
    typedef logic [$clog2(`TK_REG_CNT)-1:0] reg_idx_t;
    typedef logic [`TK_LIT_W-1:0]           lit_t;

    // Kept opcodes, encodings from the original ISA
    typedef enum logic [4:0] {
        op_and    = 5'h00,
        op_or     = 5'h01,
        op_xor    = 5'h02,
        op_not    = 5'h03,
        op_shftr  = 5'h04,
        op_shftri = 5'h05,
        op_shftl  = 5'h06,
        op_shftli = 5'h07,
        op_br     = 5'h08,
        op_brr_r  = 5'h09,
        op_brr_l  = 5'h0a,
        op_brnz   = 5'h0b,
        op_brgt   = 5'h0e,
        op_halt   = 5'h0f,
        op_load   = 5'h10,  // mov rd,(rs)(L)
        op_mov_rr = 5'h11,
        op_mov_rl = 5'h12,
        op_store  = 5'h13,  // mov (rd)(L),rs
        op_add    = 5'h18,
        op_addi   = 5'h19,
        op_sub    = 5'h1a,
        op_subi   = 5'h1b
    } opcode_t;

    typedef enum logic [1:0] {
        kind_alu,
        kind_load,
        kind_store,
        kind_other  // Branches, halt and no-ops
    } op_kind_t;

    typedef struct packed {
        addr_t                   pc;
        logic [`TK_INSTR_W-1:0]  instr;
    } fetch_pkt_t;

    typedef struct packed {
        addr_t     pc;
        opcode_t   opcode;
        op_kind_t  kind;
        reg_idx_t  rd;
        lit_t      lit;
        word_t     rd_val;
        word_t     rs_val;
        word_t     rt_val;
        logic      halt;
    } dec_pkt_t;

    typedef struct packed {
        addr_t     pc;
        reg_idx_t  rd;
        op_kind_t  kind;
        logic      writes_rd;
        word_t     result;
        addr_t     next_pc;
        addr_t     mem_addr;
        word_t     store_data;
        logic      halt;
    } exe_pkt_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        logic      writes_rd;
        reg_idx_t  rd;
        word_t     value;
    } retire_t;

    // Word write from the program loader
    typedef struct packed {
        logic                   valid;
        addr_t                  addr;
        logic [`TK_INSTR_W-1:0] data;
    } prog_wr_t;

endpackage

// ==== execute/exec_stage.sv ====
// Execute stage with integer ALU, branch resolution and address generation
`timescale 1ns/100ps
`include "tinker_macros.svh"

module exec_stage (
    input  logic                 in_valid,
    output logic                 in_ready,
    input  tinker_pkg::dec_pkt_t in_data,
    output logic                 out_valid,
    input  logic                 out_ready,
    output tinker_pkg::exe_pkt_t out_data
);
    import tinker_pkg::*;

    localparam int EXT_W = `TK_WORD_W - `TK_LIT_W;

    word_t lit_sx;
    word_t lit_zx;
    word_t result;
    addr_t pc4;
    addr_t next_pc;
    addr_t mem_addr;

    assign lit_sx = {{EXT_W{in_data.lit[`TK_LIT_W-1]}}, in_data.lit};
    assign lit_zx = {{EXT_W{1'b0}}, in_data.lit};

    always_comb begin
        case (in_data.opcode)
            op_add:    result = in_data.rs_val + in_data.rt_val;
            op_addi:   result = in_data.rd_val + lit_sx;
            op_sub:    result = in_data.rs_val - in_data.rt_val;
            op_subi:   result = in_data.rd_val - lit_zx;      // Literal unsigned here
            op_and:    result = in_data.rs_val & in_data.rt_val;
            op_or:     result = in_data.rs_val | in_data.rt_val;
            op_xor:    result = in_data.rs_val ^ in_data.rt_val;
            op_not:    result = ~in_data.rs_val;
            op_shftr:  result = in_data.rs_val >> in_data.rt_val;
            op_shftri: result = in_data.rd_val >> in_data.lit;
            op_shftl:  result = in_data.rs_val << in_data.rt_val;
            op_shftli: result = in_data.rd_val << in_data.lit;
            op_mov_rr: result = in_data.rs_val;
            op_mov_rl: result = {in_data.rd_val[`TK_WORD_W-1:`TK_LIT_W], in_data.lit};
            default:   result = '0;
        endcase
    end

    assign pc4 = in_data.pc + 32'd4;

    always_comb begin
        case (in_data.opcode)
            op_br:    next_pc = in_data.rd_val[`TK_ADDR_W-1:0];
            op_brr_r: next_pc = in_data.pc + in_data.rd_val[`TK_ADDR_W-1:0];
            op_brr_l: next_pc = in_data.pc + lit_sx[`TK_ADDR_W-1:0];
            op_brnz:
                next_pc = (in_data.rs_val != '0) ? in_data.rd_val[`TK_ADDR_W-1:0] : pc4;
            op_brgt: begin
                // Signed compare of rs against rt
                if ($signed(in_data.rs_val) > $signed(in_data.rt_val))
                    next_pc = in_data.rd_val[`TK_ADDR_W-1:0];
                else
                    next_pc = pc4;
            end
            default:  next_pc = pc4;
        endcase
    end

    // Store bases on rd, load on rs
    assign mem_addr = (in_data.kind == kind_store)
                    ? in_data.rd_val[`TK_ADDR_W-1:0] + lit_zx[`TK_ADDR_W-1:0]
                    : in_data.rs_val[`TK_ADDR_W-1:0] + lit_zx[`TK_ADDR_W-1:0];

    assign out_data = '{
        pc:         in_data.pc,
        rd:         in_data.rd,
        kind:       in_data.kind,
        writes_rd:  (in_data.kind == kind_alu) || (in_data.kind == kind_load),
        result:     result,
        next_pc:    next_pc,
        mem_addr:   mem_addr,
        store_data: in_data.rs_val,
        halt:       in_data.halt
    };

    assign out_valid = in_valid;
    assign in_ready  = out_ready;

endmodule

// ==== memory/tinker_memory.sv ====
// Unified little-endian byte memory with fetch, data and program-load ports
`timescale 1ns/100ps
`include "tinker_macros.svh"

module tinker_memory (
    input  logic                   clk,
    input  tinker_pkg::addr_t      fetch_addr,
    output logic [`TK_INSTR_W-1:0] fetch_instr,
    input  tinker_pkg::addr_t      data_addr,
    input  logic                   data_we,
    input  tinker_pkg::word_t      data_wdata,
    output tinker_pkg::word_t      data_rdata,
    input  tinker_pkg::prog_wr_t   prog
);
    import tinker_pkg::*;

    localparam int IDX_W = $clog2(`TK_MEM_BYTES);

    logic [7:0] mem [`TK_MEM_BYTES];

    // Byte index, wraps at the top of memory
    function automatic logic [IDX_W-1:0] bidx(input addr_t base, input int unsigned k);
        return IDX_W'(base + k);
    endfunction

    always_comb begin
        for (int i = 0; i < 4; i++)
            fetch_instr[8*i +: 8] = mem[bidx(fetch_addr, i)];
        for (int i = 0; i < 8; i++)
            data_rdata[8*i +: 8] = mem[bidx(data_addr, i)];
    end

    always_ff @(posedge clk) begin
        if (prog.valid) begin
            for (int i = 0; i < 4; i++)
                mem[bidx(prog.addr, i)] <= prog.data[8*i +: 8];
        end
        if (data_we) begin
            for (int i = 0; i < 8; i++)
                mem[bidx(data_addr, i)] <= data_wdata[8*i +: 8];
        end
    end

    writes_in_range: assert property (@(posedge clk)
        (!data_we || data_addr <= `TK_MEM_BYTES - 8) &&
        (!prog.valid || prog.addr <= `TK_MEM_BYTES - 4));

endmodule

// ==== verif/tb_checks.sv ====
// Reference model of the Tinker ISA and the concurrent checks on the core ports
`timescale 1ns/100ps
`include "tinker_macros.svh"

module tb_checks (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  tinker_pkg::prog_wr_t prog,
    input  tinker_pkg::retire_t  retire,
    input  logic                 hlt,
    output int                   err_cnt,
    output int                   retire_cnt
);
    import tinker_pkg::*;

    word_t      sregs [`TK_REG_CNT];     // Shadow registers
    logic [7:0] smem [`TK_MEM_BYTES];    // Shadow memory, fed by prog and stores
    addr_t      pred_pc;                 // Where the next retire must come from
    addr_t      exp_pc;
    addr_t      exp_next;
    logic       exp_writes;
    logic       exp_store;
    logic       exp_halt;
    reg_idx_t   exp_rd;
    word_t      exp_value;
    addr_t      st_addr;
    word_t      st_data;

    initial err_cnt = 0;

    // Little-endian read of n bytes
    function automatic word_t load_le(input addr_t a, input int n);
        word_t w;
        w = '0;
        for (int i = n - 1; i >= 0; i--)
            w = {w[55:0], smem[16'(a + i)]};
        return w;
    endfunction

    // Expected effect of the instruction at retire.pc
    task automatic predict();
        word_t       raw;
        logic [31:0] ins;
        logic [4:0]  op;
        lit_t        l;
        word_t       vd, vs, vt, sx, zx;
        raw = load_le(retire.pc, 4);
        ins = raw[31:0];
        op  = ins[31:27];
        l   = ins[11:0];
        exp_rd = ins[26:22];
        vd = sregs[ins[26:22]];
        vs = sregs[ins[21:17]];
        vt = sregs[ins[16:12]];
        sx = {{52{l[11]}}, l};
        zx = {52'd0, l};
        exp_value = '0;
        exp_next  = retire.pc + 32'd4;
        exp_store = 1'b0;
        exp_halt  = (op == op_halt);
        exp_writes = op inside {op_add, op_addi, op_sub, op_subi, op_and, op_or, op_xor,
                                op_not, op_shftr, op_shftri, op_shftl, op_shftli,
                                op_mov_rr, op_mov_rl, op_load};
        case (op)
            op_add:    exp_value = vs + vt;
            op_addi:   exp_value = vd + sx;
            op_sub:    exp_value = vs - vt;
            op_subi:   exp_value = vd - zx;
            op_and:    exp_value = vs & vt;
            op_or:     exp_value = vs | vt;
            op_xor:    exp_value = vs ^ vt;
            op_not:    exp_value = ~vs;
            op_shftr:  exp_value = (vt < 64) ? vs >> vt[5:0] : '0;
            op_shftri: exp_value = (l < 64) ? vd >> l[5:0] : '0;
            op_shftl:  exp_value = (vt < 64) ? vs << vt[5:0] : '0;
            op_shftli: exp_value = (l < 64) ? vd << l[5:0] : '0;
            op_mov_rr: exp_value = vs;
            op_mov_rl: exp_value = {vd[63:12], l};
            op_load:   exp_value = load_le(addr_t'(vs + zx), 8);
            op_store: begin
                exp_store = 1'b1;
                st_addr   = addr_t'(vd + zx);
                st_data   = vs;
            end
            op_br:     exp_next = vd[31:0];
            op_brr_r:  exp_next = retire.pc + vd[31:0];
            op_brr_l:  exp_next = retire.pc + sx[31:0];
            op_brnz:   if (vs != '0) exp_next = vd[31:0];
            op_brgt:   if ($signed(vs) > $signed(vt)) exp_next = vd[31:0];
            default:   ;                          // Dropped or unknown, a no-op
        endcase
    endtask

    // Model steps at the falling edge, where the core outputs are settled
    always @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TK_REG_CNT; i++)
                sregs[i] = '0;
            pred_pc    = `TK_RESET_PC;
            retire_cnt = 0;
        end else begin
            if (prog.valid) begin
                for (int i = 0; i < 4; i++)
                    smem[16'(prog.addr + i)] = prog.data[8*i +: 8];
            end
            if (retire.valid) begin
                predict();
                exp_pc  = pred_pc;
                pred_pc = exp_next;
                if (exp_writes)
                    sregs[exp_rd] = exp_value;
                if (exp_store) begin
                    for (int i = 0; i < 8; i++)
                        smem[16'(st_addr + i)] = st_data[8*i +: 8];
                end
                retire_cnt++;
            end
        end
    end

    idle_before_start: assert property (@(posedge clk) disable iff (reset)
        !start |-> (!retire.valid && !hlt))
        else begin
            err_cnt++;
            $display("Core retired or halted before start was raised");
        end

    pc_follows: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> retire.pc == exp_pc)
        else begin
            err_cnt++;
            $display("CHECK FAILED retire.pc: got %h, expected %h", $sampled(retire.pc), exp_pc);
        end

    writes_match: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> retire.writes_rd == exp_writes)
        else begin
            err_cnt++;
            $display("CHECK FAILED retire.writes_rd: got %h, expected %h at pc %h",
                     $sampled(retire.writes_rd), exp_writes, exp_pc);
        end

    rd_match: assert property (@(posedge clk) disable iff (reset)
        (retire.valid && exp_writes) |-> retire.rd == exp_rd)
        else begin
            err_cnt++;
            $display("CHECK FAILED retire.rd: got %h, expected %h", $sampled(retire.rd), exp_rd);
        end

    value_match: assert property (@(posedge clk) disable iff (reset)
        (retire.valid && exp_writes) |-> retire.value == exp_value)
        else begin
            err_cnt++;
            $display("CHECK FAILED retire.value: got %h, expected %h at pc %h",
                     $sampled(retire.value), exp_value, exp_pc);
        end

    halt_raises: assert property (@(posedge clk) disable iff (reset)
        (retire.valid && exp_halt) |=> hlt)
        else begin
            err_cnt++;
            $display("hlt did not rise after the halt instruction retired");
        end

    quiet_after_halt: assert property (@(posedge clk) disable iff (reset)
        hlt |-> (!retire.valid ##1 hlt))
        else begin
            err_cnt++;
            $display("Core retired again or dropped hlt after halting");
        end

endmodule

// ==== verif/tb_tinker.sv ====
// Testbench top with clock, reset, program build and load, watchdog and verdict
`timescale 1ns/100ps
`include "tinker_macros.svh"

module tb_tinker;
    import tinker_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DATA_BASE  = 'h800;    // Seed words placed by prog
    localparam int SEED_WORDS = 8;

    logic        clk;
    logic        reset;
    logic        start;
    prog_wr_t    prog;
    retire_t     retire;
    logic        hlt;
    int          err_cnt;
    int          retire_cnt;
    logic [31:0] code [$];                // Program image from TK_RESET_PC up
    word_t       seed_word;

    tinker_core i_tinker_core (.clk, .reset, .start, .prog, .retire, .hlt);

    tb_checks i_checks (.clk, .reset, .start, .prog, .retire, .hlt, .err_cnt, .retire_cnt);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int pick_reg(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    task automatic emit(input logic [4:0] op, input int rd, input int rs, input int rt,
                        input int lit);
        code.push_back({op, 5'(rd), 5'(rs), 5'(rt), 12'(lit)});
    endtask

    // Builds the target in r24, then branches over one filler instruction
    task automatic emit_far_branch(input logic [4:0] op, input int rs, input int rt);
        addr_t target;
        target = `TK_RESET_PC + 4 * (code.size() + 6);
        emit(op_mov_rr, 24, 0, 0, 0);
        emit(op_mov_rl, 24, 0, 0, target >> 4);
        emit(op_shftli, 24, 0, 0, 4);
        emit(op_addi, 24, 0, 0, target & 'hf);
        emit(op, 24, rs, rt, 0);
        emit(op_xor, 25, 1, 2, 0);        // Skipped when taken
    endtask

    task automatic build_program();
        logic [4:0] alu_ops [14];
        logic [4:0] dropped [6];
        int         off;
        int         rt;
        int         lit;
        alu_ops = '{op_add, op_addi, op_sub, op_subi, op_and, op_or, op_xor, op_not,
                    op_shftr, op_shftri, op_shftl, op_shftli, op_mov_rr, op_mov_rl};
        dropped = '{5'h0c, 5'h0d, 5'h14, 5'h17, 5'h1c, 5'h1f};   // call, return, fp, mul...
        for (int k = 0; k < SEED_WORDS; k++)
            emit(op_load, k + 1, 0, 0, DATA_BASE + 8 * k);
        emit(op_mov_rl, 9, 0, 0, 1 + int'($urandom % 63));     // Short shift count in r9
        for (int rep = 0; rep < 2; rep++) begin
            foreach (alu_ops[i]) begin
                rt  = pick_reg(1, 8);
                lit = int'($urandom);
                if (alu_ops[i] inside {op_shftr, op_shftl})
                    rt = 9;
                else if (alu_ops[i] inside {op_shftri, op_shftli})
                    lit = int'($urandom % 64);
                emit(alu_ops[i], pick_reg(10, 20), pick_reg(1, 8), rt, lit);
            end
        end
        for (int n = 0; n < 3; n++) begin
            off = 'h900 + 8 * int'($urandom % 200);
            emit(op_store, 0, pick_reg(1, 20), 0, off);      // Base r0 stays zero
            emit(op_load, pick_reg(10, 20), 0, 0, off);
        end
        emit_far_branch(op_br, 0, 0);
        emit_far_branch(op_brnz, 1, 0);   // Taken
        emit_far_branch(op_brnz, 0, 0);   // Not taken
        emit_far_branch(op_brgt, 1, 2);
        emit_far_branch(op_brgt, 2, 1);
        emit(op_mov_rr, 23, 0, 0, 0);
        emit(op_mov_rl, 23, 0, 0, 8);
        emit(op_brr_r, 23, 0, 0, 0);
        emit(op_xor, 25, 1, 2, 0);
        emit(op_brr_l, 0, 0, 0, 8);
        emit(op_xor, 25, 2, 1, 0);
        foreach (dropped[i])
            emit(dropped[i], pick_reg(10, 20), pick_reg(1, 8), pick_reg(1, 8), $urandom);
        emit(op_halt, 0, 0, 0, 0);
    endtask

    // One prog word per cycle, driven just after the edge
    task automatic write_word(input addr_t addr, input logic [31:0] data);
        @(posedge clk);
        #10;
        prog = '{valid: 1'b1, addr: addr, data: data};
    endtask

    initial begin
        void'($urandom(39));
        reset = 1'b1;
        start = 1'b0;
        prog  = '0;
        build_program();
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;
        for (int k = 0; k < SEED_WORDS; k++) begin
            seed_word = {$urandom, $urandom};
            write_word(DATA_BASE + 8 * k, seed_word[31:0]);
            write_word(DATA_BASE + 8 * k + 4, seed_word[63:32]);
        end
        foreach (code[i])
            write_word(`TK_RESET_PC + 4 * i, code[i]);
        @(posedge clk);
        #10;
        prog  = '0;
        start = 1'b1;
        while (!hlt)
            @(posedge clk);
        repeat (16) @(posedge clk);       // Quiet window after halt
        $display("Retired %0d instructions, %0d errors", retire_cnt, err_cnt);
        if (err_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // Four cycles per instruction, with a margin of three
    initial begin
        wait (start === 1'b1);
        repeat (code.size() * 4 * 3) @(posedge clk);
        $display("Timeout, the halt instruction never retired");
        $display("Retired %0d instructions, %0d errors", retire_cnt, err_cnt);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== verilog/commit_stage.sv ====
// Commit stage with memory access, write-back, PC redirect, retire report and halt
`timescale 1ns/100ps

module commit_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  tinker_pkg::exe_pkt_t in_data,
    output tinker_pkg::addr_t    mem_addr,
    output logic                 mem_we,
    output tinker_pkg::word_t    mem_wdata,
    input  tinker_pkg::word_t    mem_rdata,
    output logic                 rf_we,
    output tinker_pkg::reg_idx_t rf_idx,
    output tinker_pkg::word_t    rf_data,
    output logic                 redirect_valid,
    output tinker_pkg::addr_t    redirect_pc,
    output tinker_pkg::retire_t  retire,
    output logic                 hlt
);
    import tinker_pkg::*;

    assign in_ready = 1'b1;   // Single cycle, never stalls

    assign mem_addr  = in_data.mem_addr;
    assign mem_we    = in_valid && (in_data.kind == kind_store);
    assign mem_wdata = in_data.store_data;

    assign rf_we   = in_valid && in_data.writes_rd;
    assign rf_idx  = in_data.rd;
    assign rf_data = (in_data.kind == kind_load) ? mem_rdata : in_data.result;

    // Halt gives no PC back, so fetch goes quiet
    assign redirect_valid = in_valid && !in_data.halt;
    assign redirect_pc    = in_data.next_pc;

    assign retire = '{
        valid:     in_valid,
        pc:        in_data.pc,
        writes_rd: in_data.writes_rd,
        rd:        in_data.rd,
        value:     rf_data
    };

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hlt <= 1'b0;
        end else if (in_valid && in_data.halt) begin
            hlt <= 1'b1;
        end
    end

    // Nothing is left in the pipe once halted
    quiet_after_halt: assert property (@(posedge clk) disable iff (reset)
        hlt |-> !in_valid);

endmodule

// ==== verilog/decode_stage.sv ====
// Decode stage with field split, register reads and kind/halt classification
`timescale 1ns/100ps

module decode_stage (
    input  logic                   in_valid,
    output logic                   in_ready,
    input  tinker_pkg::fetch_pkt_t in_data,
    output tinker_pkg::reg_idx_t   rd_idx,
    output tinker_pkg::reg_idx_t   rs_idx,
    output tinker_pkg::reg_idx_t   rt_idx,
    input  tinker_pkg::word_t      rd_val,
    input  tinker_pkg::word_t      rs_val,
    input  tinker_pkg::word_t      rt_val,
    output logic                   out_valid,
    input  logic                   out_ready,
    output tinker_pkg::dec_pkt_t   out_data
);
    import tinker_pkg::*;

    opcode_t  opcode;
    op_kind_t kind;

    assign opcode = opcode_t'(in_data.instr[31:27]);
    assign rd_idx = in_data.instr[26:22];
    assign rs_idx = in_data.instr[21:17];
    assign rt_idx = in_data.instr[16:12];

    always_comb begin
        case (opcode)
            op_add, op_addi, op_sub, op_subi,
            op_and, op_or, op_xor, op_not,
            op_shftr, op_shftri, op_shftl, op_shftli,
            op_mov_rr, op_mov_rl:  kind = kind_alu;
            op_load:               kind = kind_load;
            op_store:              kind = kind_store;
            default:               kind = kind_other;  // Branches, halt, unknown
        endcase
    end

    assign out_data = '{
        pc:     in_data.pc,
        opcode: opcode,
        kind:   kind,
        rd:     rd_idx,
        lit:    in_data.instr[11:0],
        rd_val: rd_val,
        rs_val: rs_val,
        rt_val: rt_val,
        halt:   (opcode == op_halt)
    };

    assign out_valid = in_valid;
    assign in_ready  = out_ready;

endmodule

// ==== verilog/fetch_stage.sv ====
// Fetch stage with the PC register, issue token and instruction fetch
`timescale 1ns/100ps
`include "tinker_macros.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   redirect_valid,
    input  tinker_pkg::addr_t      redirect_pc,
    output tinker_pkg::addr_t      fetch_addr,
    input  logic [`TK_INSTR_W-1:0] fetch_instr,
    output logic                   out_valid,
    input  logic                   out_ready,
    output tinker_pkg::fetch_pkt_t out_data
);
    import tinker_pkg::*;

    addr_t pc;
    logic  token;     // One instruction may be issued
    logic  started;
    logic  launch;    // First cycle of start

    assign launch    = start && !started;
    assign out_valid = token || launch;
    assign fetch_addr = pc;
    assign out_data  = '{pc: pc, instr: fetch_instr};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= `TK_RESET_PC;
            token   <= 1'b0;
            started <= 1'b0;
        end else begin
            if (launch)
                started <= 1'b1;
            if (redirect_valid) begin
                pc    <= redirect_pc;
                token <= 1'b1;
            end else if (out_valid && out_ready) begin
                token <= 1'b0;
            end else if (launch) begin
                token <= 1'b1;      // Launch stalled, keep offering it
            end
        end
    end

    // Commit only sends a PC back once the issued item has drained
    single_in_flight: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |-> !token);

endmodule

// ==== verilog/reg_file.sv ====
// Register file, 32 x 64 bits, three combinational reads and one write
`timescale 1ns/100ps
`include "tinker_macros.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::reg_idx_t rd_idx,
    input  tinker_pkg::reg_idx_t rs_idx,
    input  tinker_pkg::reg_idx_t rt_idx,
    output tinker_pkg::word_t    rd_val,
    output tinker_pkg::word_t    rs_val,
    output tinker_pkg::word_t    rt_val,
    input  logic                 we,
    input  tinker_pkg::reg_idx_t wr_idx,
    input  tinker_pkg::word_t    wr_data
);
    import tinker_pkg::*;

    word_t regs [`TK_REG_CNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `TK_REG_CNT; i++)
                regs[i] <= '0;   // No stack pointer preset
        end else if (we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_val = regs[rd_idx];
    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

endmodule

// ==== verilog/stage_reg.sv ====
// One-entry valid/ready pipeline register with a type-parameterized payload
`timescale 1ns/100ps

module stage_reg #(
    parameter type payload_t = tinker_pkg::fetch_pkt_t
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Free slot, or the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // Upstream keeps its offer steady while this slot is full
    hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_data)));

endmodule

// ==== verilog/tinker_core.sv ====
// Tinker core top level joining the four stages, register file and memory
`timescale 1ns/100ps
`include "tinker_macros.svh"

module tinker_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  tinker_pkg::prog_wr_t prog,
    output tinker_pkg::retire_t  retire,
    output logic                 hlt
);
    import tinker_pkg::*;

    fetch_pkt_t f_pkt, fd_pkt;
    dec_pkt_t   d_pkt, de_pkt;
    exe_pkt_t   e_pkt, ec_pkt;
    logic       f_valid, f_ready, fd_valid, fd_ready;
    logic       d_valid, d_ready, de_valid, de_ready;
    logic       e_valid, e_ready, ec_valid, ec_ready;

    logic                   redir_valid;
    addr_t                  redir_pc;
    addr_t                  fetch_addr;
    logic [`TK_INSTR_W-1:0] fetch_instr;
    reg_idx_t               rd_idx, rs_idx, rt_idx, rf_idx;
    word_t                  rd_val, rs_val, rt_val, rf_data;
    logic                   rf_we;
    addr_t                  mem_addr;
    logic                   mem_we;
    word_t                  mem_wdata, mem_rdata;

    fetch_stage u_fetch (
        .clk, .reset, .start,
        .redirect_valid(redir_valid), .redirect_pc(redir_pc),
        .fetch_addr, .fetch_instr,
        .out_valid(f_valid), .out_ready(f_ready), .out_data(f_pkt)
    );

    stage_reg #(.payload_t(fetch_pkt_t)) u_fd (
        .clk, .reset,
        .in_valid(f_valid), .in_ready(f_ready), .in_data(f_pkt),
        .out_valid(fd_valid), .out_ready(fd_ready), .out_data(fd_pkt)
    );

    decode_stage u_decode (
        .in_valid(fd_valid), .in_ready(fd_ready), .in_data(fd_pkt),
        .rd_idx, .rs_idx, .rt_idx, .rd_val, .rs_val, .rt_val,
        .out_valid(d_valid), .out_ready(d_ready), .out_data(d_pkt)
    );

    stage_reg #(.payload_t(dec_pkt_t)) u_de (
        .clk, .reset,
        .in_valid(d_valid), .in_ready(d_ready), .in_data(d_pkt),
        .out_valid(de_valid), .out_ready(de_ready), .out_data(de_pkt)
    );

    exec_stage u_exec (
        .in_valid(de_valid), .in_ready(de_ready), .in_data(de_pkt),
        .out_valid(e_valid), .out_ready(e_ready), .out_data(e_pkt)
    );

    stage_reg #(.payload_t(exe_pkt_t)) u_ec (
        .clk, .reset,
        .in_valid(e_valid), .in_ready(e_ready), .in_data(e_pkt),
        .out_valid(ec_valid), .out_ready(ec_ready), .out_data(ec_pkt)
    );

    commit_stage u_commit (
        .clk, .reset,
        .in_valid(ec_valid), .in_ready(ec_ready), .in_data(ec_pkt),
        .mem_addr, .mem_we, .mem_wdata, .mem_rdata,
        .rf_we, .rf_idx, .rf_data,
        .redirect_valid(redir_valid), .redirect_pc(redir_pc),
        .retire, .hlt
    );

    reg_file u_rf (
        .clk, .reset,
        .rd_idx, .rs_idx, .rt_idx, .rd_val, .rs_val, .rt_val,
        .we(rf_we), .wr_idx(rf_idx), .wr_data(rf_data)
    );

    tinker_memory u_mem (
        .clk, .fetch_addr, .fetch_instr,
        .data_addr(mem_addr), .data_we(mem_we),
        .data_wdata(mem_wdata), .data_rdata(mem_rdata),
        .prog
    );

endmodule
